/* rtl/boot_pkg.sv */
package boot_pkg;

	typedef logic [31:0] addr_t;	// byte address
	typedef logic [31:0] instr_t;	// raw rv32 word

	// one memory write from the loader
	typedef struct packed {
		addr_t  addr;
		instr_t instr;
	} load_beat_t;

	// fetch output toward the (out of scope) pipeline
	typedef struct packed {
		logic   valid;
		addr_t  pc;
		instr_t instr;
	} fetch_t;

	localparam int PROG_LEN = 21;	// words in the boot image
	localparam addr_t BOOT_BASE = 32'h0000_0000;	// word i at BOOT_BASE + 4*i
	localparam instr_t EBREAK_INSTR = {12'h001, 5'd0, 3'b000, 5'd0, 7'b1110011};

	// boot image, ebreak at index 10
	localparam instr_t boot_program [PROG_LEN] = '{
		{12'h007, 5'd0, 3'b111, 5'd7, 7'b0010011},	// andi x7,x0,7
		{12'h008, 5'd0, 3'b111, 5'd6, 7'b0010011},
		{12'h005, 5'd0, 3'b111, 5'd7, 7'b0010011},
		{12'h005, 5'd0, 3'b111, 5'd4, 7'b0010011},
		{12'h005, 5'd0, 3'b111, 5'd4, 7'b0010011},
		{12'h005, 5'd0, 3'b111, 5'd4, 7'b0010011},
		{12'h005, 5'd0, 3'b111, 5'd5, 7'b0010011},
		{12'h005, 5'd0, 3'b111, 5'd6, 7'b0010011},
		{12'h005, 5'd0, 3'b111, 5'd4, 7'b0010011},
		{12'h005, 5'd0, 3'b111, 5'd7, 7'b0010011},
		{12'h001, 5'd0, 3'b000, 5'd0, 7'b1110011},	// ebreak, fetch stops here
		{12'h005, 5'd0, 3'b111, 5'd6, 7'b0010011},
		{12'h002, 5'd0, 3'b111, 5'd3, 7'b0010011},
		{12'h002, 5'd0, 3'b111, 5'd1, 7'b0010011},
		{12'h001, 5'd0, 3'b111, 5'd14, 7'b0010011},
		{12'h341, 5'd24, 3'b101, 5'd1, 7'b1110011},	// csrrwi mepc
		{12'h100, 5'd7, 3'b101, 5'd1, 7'b1110011},	// sstatus
		{12'h300, 5'd10, 3'b101, 5'd1, 7'b1110011},	// mstatus
		{12'h302, 5'd4, 3'b101, 5'd1, 7'b1110011},	// medeleg
		{12'h041, 5'd20, 3'b101, 5'd1, 7'b1110011},
		{12'h305, 5'd20, 3'b101, 5'd1, 7'b1110011}	// mtvec
	};

endpackage

/* rtl/debug_loader.sv */
module debug_loader
	import boot_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
)
(
	input  logic       clk,
	input  logic       nrst,
	input  logic       credit_ret,	// one pulse per entry freed downstream
	output load_beat_t beat,
	output logic       beat_valid
);

	localparam int IDX_W  = $clog2(PROG_LEN + 1);
	localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

	logic [IDX_W-1:0]  idx;	// next word to send
	logic [CRED_W-1:0] credits;	// free slots we may still fill
	logic              load_done;
	logic              send;

	// all words handed out, stays set until reset
	assign load_done = (idx == IDX_W'(PROG_LEN));

	// only send with a credit in hand so the FIFO can never overflow
	assign send = !load_done && (credits != '0);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			idx        <= '0;
			credits    <= CRED_W'(FIFO_DEPTH);	// FIFO starts empty
			beat_valid <= 1'b0;
		end
		else
		begin
			beat_valid <= send;
			if (send)
				idx <= idx + 1'b1;
			case ({send, credit_ret})
				2'b10: credits <= credits - 1'b1;	// spent one
				2'b01: credits <= credits + 1'b1;	// got one back
				default: ;	// both or neither, net zero
			endcase
		end
	end

	// payload register, qualified by beat_valid
	always_ff @(posedge clk)
	begin
		if (send)
		begin
			beat.addr  <= BOOT_BASE + (addr_t'(idx) << 2);
			beat.instr <= boot_program[idx];
		end
	end

endmodule

/* rtl/credit_fifo.sv */
module credit_fifo #(
	parameter int  DEPTH     = 4,
	parameter type payload_t = logic [31:0]
)
(
	input  logic     clk,
	input  logic     nrst,
	input  logic     push,
	input  payload_t in_data,
	input  logic     pop,
	output payload_t out_data,
	output logic     out_valid,	// not empty
	output logic     credit_ret	// one cycle after each pop
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t           mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   count;	// occupancy
	logic               do_pop;

	// the sender's credits keep push off a full buffer
	assign do_pop    = pop && out_valid;	// ignore pop on empty
	assign out_valid = (count != '0);
	assign out_data  = mem[rd_ptr];	// head shows one cycle after push

	function automatic logic [PTR_W-1:0] wrap_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1))
			return '0;
		else
			return p + 1'b1;
	endfunction

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			credit_ret <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= wrap_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= wrap_inc(rd_ptr);
			case ({push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;	// simultaneous push and pop keeps count
			endcase
			credit_ret <= do_pop;	// freed slot goes back as a credit
		end
	end

	// entry storage
	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

endmodule

/* rtl/instr_mem.sv */
module instr_mem
	import boot_pkg::*;
#(
	parameter int MEM_WORDS = 32	// must hold at least PROG_LEN words
)
(
	input  logic       clk,
	input  logic       nrst,
	input  logic       stall,	// memory busy with another master
	input  load_beat_t in_beat,
	input  logic       in_valid,
	output logic       pop,
	output logic       start,	// whole image written
	input  logic       rd_en,
	input  addr_t      rd_addr,
	output instr_t     rd_data
);

	localparam int WIDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
	localparam int CNT_W  = $clog2(PROG_LEN + 1);

	instr_t            mem [MEM_WORDS];
	logic [CNT_W-1:0]  wr_count;	// words written so far
	addr_t             wr_off;
	addr_t             rd_off;
	logic [WIDX_W-1:0] wr_idx;
	logic [WIDX_W-1:0] rd_idx;

	// take the waiting beat whenever the port is free
	assign pop = in_valid && !stall;

	// byte address to word index, relative to the boot base
	assign wr_off = in_beat.addr - BOOT_BASE;
	assign rd_off = rd_addr - BOOT_BASE;
	assign wr_idx = wr_off[WIDX_W+1:2];
	assign rd_idx = rd_off[WIDX_W+1:2];

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			wr_count <= '0;
			start    <= 1'b0;
		end
		else
		begin
			if (pop)
				wr_count <= wr_count + 1'b1;
			// sticky once every word has landed
			if (wr_count == CNT_W'(PROG_LEN))
				start <= 1'b1;
		end
	end

	// write on the edge that ends the pop cycle
	always_ff @(posedge clk)
	begin
		if (pop)
			mem[wr_idx] <= in_beat.instr;
	end

	// registered read, data one cycle after rd_en
	always_ff @(posedge clk)
	begin
		if (rd_en)
			rd_data <= mem[rd_idx];
	end

endmodule

/* rtl/fetch_unit.sv */
module fetch_unit
	import boot_pkg::*;
(
	input  logic   clk,
	input  logic   nrst,
	input  logic   start,
	output logic   rd_en,
	output addr_t  rd_addr,
	input  instr_t rd_data,
	output fetch_t fetch,
	output logic   halted
);

	addr_t  pc;	// next address to read
	addr_t  pc_q;	// pc of the read in flight
	logic   rd_pending;	// rd_data valid this cycle
	logic   ebreak_seen;
	logic   fetch_valid;
	addr_t  fetch_pc;
	instr_t fetch_instr;

	// one read per cycle until the ebreak shows up
	assign rd_en   = start && !ebreak_seen;
	assign rd_addr = pc;
	assign fetch   = '{valid: fetch_valid, pc: fetch_pc, instr: fetch_instr};

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pc          <= BOOT_BASE;
			rd_pending  <= 1'b0;
			ebreak_seen <= 1'b0;
			fetch_valid <= 1'b0;
			halted      <= 1'b0;
		end
		else
		begin
			if (rd_en)
				pc <= pc + 32'd4;	// strictly sequential
			rd_pending <= rd_en;
			if (rd_pending && (rd_data == EBREAK_INSTR))
				ebreak_seen <= 1'b1;
			// read already in flight behind the ebreak gets dropped
			fetch_valid <= rd_pending && !ebreak_seen;
			halted      <= ebreak_seen;	// one cycle after the ebreak valid
		end
	end

	// payload side, qualified by fetch_valid
	always_ff @(posedge clk)
	begin
		if (rd_en)
			pc_q <= pc;
		if (rd_pending)
		begin
			fetch_pc    <= pc_q;
			fetch_instr <= rd_data;
		end
	end

endmodule

/* rtl/boot_top.sv */
module boot_top
	import boot_pkg::*;
#(
	parameter int FIFO_DEPTH = 4,
	parameter int MEM_WORDS  = 32	// at least PROG_LEN
)
(
	input  logic   clk,
	input  logic   nrst,
	input  logic   stall,
	output logic   start,
	output fetch_t fetch,
	output logic   halted
);

	load_beat_t beat;
	logic       beat_valid;
	logic       credit_ret;
	load_beat_t out_beat;
	logic       out_valid;
	logic       pop;
	logic       rd_en;
	addr_t      rd_addr;
	instr_t     rd_data;

	debug_loader #(.FIFO_DEPTH(FIFO_DEPTH)) u_loader (
		.clk       (clk),
		.nrst      (nrst),
		.credit_ret(credit_ret),
		.beat      (beat),
		.beat_valid(beat_valid)
	);

	// credit loop sized by the same depth as the loader's counter
	credit_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(load_beat_t)) u_fifo (
		.clk       (clk),
		.nrst      (nrst),
		.push      (beat_valid),
		.in_data   (beat),
		.pop       (pop),
		.out_data  (out_beat),
		.out_valid (out_valid),
		.credit_ret(credit_ret)
	);

	instr_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (
		.clk     (clk),
		.nrst    (nrst),
		.stall   (stall),
		.in_beat (out_beat),
		.in_valid(out_valid),
		.pop     (pop),
		.start   (start),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	fetch_unit u_fetch (
		.clk    (clk),
		.nrst   (nrst),
		.start  (start),
		.rd_en  (rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.fetch  (fetch),
		.halted (halted)
	);

endmodule

/* verification/boot_checker.sv */
module boot_checker #(
	parameter int DEPTH = 4
)
(
	input logic                       clk,
	input logic                       nrst,
	input logic                       push,
	input logic [$clog2(DEPTH+1)-1:0] count,	// fifo occupancy
	input logic [$clog2(DEPTH+1)-1:0] credits,	// loader side counter
	input logic                       start,
	input logic                       fetch_valid
);

	int fail_cnt = 0;	// assertion failures so far

	// loader never holds more credits than slots
	a_credit_max: assert property (@(posedge clk) disable iff (!nrst)
		credits <= DEPTH)
		else
		begin
			fail_cnt++;
			$error("loader credit count above fifo depth");
		end

	// credits should make this impossible
	a_no_push_full: assert property (@(posedge clk) disable iff (!nrst)
		!(push && (count == DEPTH)))
		else
		begin
			fail_cnt++;
			$error("push into a full fifo");
		end

	a_start_sticky: assert property (@(posedge clk) disable iff (!nrst)
		start |=> start)	// stays up until the next reset
		else
		begin
			fail_cnt++;
			$error("start fell after rising");
		end

	a_fetch_after_start: assert property (@(posedge clk) disable iff (!nrst)
		fetch_valid |-> start)
		else
		begin
			fail_cnt++;
			$error("fetch valid seen before start");
		end

endmodule

/* verification/boot_tb.sv */
module boot_tb
	import boot_pkg::*;
;

	localparam int FIFO_DEPTH  = 4;
	localparam int MEM_WORDS   = 32;
	localparam int PHASE_LIMIT = 20 * PROG_LEN + 100;	// cycles allowed per phase
	localparam int QUIET_CYC   = 10;	// no valids this long after halt

	// one expected fetch
	typedef struct packed {
		logic [7:0] idx;
		addr_t      pc;
		instr_t     instr;
	} exp_entry_t;

	logic        clk;
	logic        nrst;
	logic        stall;
	logic        start;
	fetch_t      fetch;
	logic        halted;

	exp_entry_t  exp_tab [$];	// expected pc/instr stream
	logic [31:0] rng_state;
	logic        rand_stall;	// phase select for the stall driver
	int          phase_cyc;
	int          value_errs;
	int          timing_errs;
	int          assert_errs;

	boot_top #(.FIFO_DEPTH(FIFO_DEPTH), .MEM_WORDS(MEM_WORDS)) DUT (
		.clk   (clk),
		.nrst  (nrst),
		.stall (stall),
		.start (start),
		.fetch (fetch),
		.halted(halted)
	);

	bind credit_fifo boot_checker #(.DEPTH(DEPTH)) u_checker (
		.clk        (clk),
		.nrst       (nrst),
		.push       (push),
		.count      (count),
		.credits    (boot_tb.DUT.u_loader.credits),
		.start      (boot_tb.DUT.start),
		.fetch_valid(boot_tb.DUT.fetch.valid)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// stall about one cycle in four, set just after the rising edge
	always @(posedge clk)
	begin
		#1;
		if (rand_stall)
		begin
			rng_state = xorshift32(rng_state);
			stall = (rng_state[1:0] == 2'b00);
		end
		else
			stall = 1'b0;
	end

	// watchdog cleared at each reset
	always @(posedge clk)
	begin
		phase_cyc = phase_cyc + 1;
		if (phase_cyc > PHASE_LIMIT)
		begin
			$display("Timeout: phase did not finish within %0d cycles", PHASE_LIMIT);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// program words up to and including the ebreak
	function automatic void build_table();
		exp_entry_t e;
		exp_tab.delete();
		for (int i = 0; i < PROG_LEN; i++)
		begin
			e.idx   = 8'(i);
			e.pc    = BOOT_BASE + 32'(4 * i);
			e.instr = boot_program[i];
			exp_tab.push_back(e);
			if (boot_program[i] == EBREAK_INSTR)
				break;
		end
	endfunction

	task automatic check_idle(input string when_txt);
		assert (!start && !halted && !fetch.valid)
		else
		begin
			value_errs++;
			$display("Error %0t: %s, start=%b halted=%b valid=%b",
				$time, when_txt, start, halted, fetch.valid);
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1;
		nrst = 1'b0;
		phase_cyc = 0;
		@(negedge clk);
		check_idle("outputs active during reset");
		@(posedge clk);
		@(posedge clk);
		#1;
		nrst = 1'b1;	// held two cycles
		@(negedge clk);
		check_idle("outputs active right after reset");
	endtask

	task automatic run_phase(input logic use_rand, input string name);
		int gap;
		rand_stall = use_rand;
		apply_reset();
		while (!start)
			@(negedge clk);	// watchdog bounds this
		for (int n = 0; n < exp_tab.size(); n++)
		begin
			gap = 0;
			do
			begin
				@(negedge clk);
				gap++;
			end while (!fetch.valid);
			// first valid 2 cycles after start and back to back after that
			assert (gap == ((n == 0) ? 2 : 1))
			else
			begin
				timing_errs++;
				$display("Error %0t: [%s] entry %0d came after %0d cycles",
					$time, name, n, gap);
			end
			assert ((fetch.pc == exp_tab[n].pc) && (fetch.instr == exp_tab[n].instr))
			else
			begin
				value_errs++;
				$display("Error %0t: [%s] entry %0d got pc %h instr %h, want pc %h instr %h",
					$time, name, exp_tab[n].idx, fetch.pc, fetch.instr,
					exp_tab[n].pc, exp_tab[n].instr);
			end
		end
		@(negedge clk);
		// the read in flight behind the ebreak would show up here
		assert (halted && !fetch.valid)
		else
		begin
			timing_errs++;
			$display("Error %0t: [%s] cycle after ebreak, halted=%b valid=%b",
				$time, name, halted, fetch.valid);
		end
		repeat (QUIET_CYC)
		begin
			@(negedge clk);
			assert (!fetch.valid && halted)
			else
			begin
				value_errs++;
				$display("Error %0t: [%s] activity after halt, valid=%b halted=%b",
					$time, name, fetch.valid, halted);
			end
		end
	endtask

	initial
	begin
		nrst        = 1'b0;
		stall       = 1'b0;
		rand_stall  = 1'b0;
		rng_state   = 32'd38495;
		phase_cyc   = 0;
		value_errs  = 0;
		timing_errs = 0;
		assert_errs = 0;
		build_table();
		run_phase(1'b1, "random stall");
		run_phase(1'b0, "no stall");	// fresh reset inside
		assert_errs = DUT.u_fifo.u_checker.fail_cnt;
		$display("value errors: %0d, timing errors: %0d, assertion errors: %0d",
			value_errs, timing_errs, assert_errs);
		if ((value_errs + timing_errs + assert_errs) == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* sim.f */
rtl/boot_pkg.sv
rtl/debug_loader.sv
rtl/credit_fifo.sv
rtl/instr_mem.sv
rtl/fetch_unit.sv
rtl/boot_top.sv
verification/boot_checker.sv
verification/boot_tb.sv
